/* rtl/evlog_macros.svh */
// ****************************************
// Event logger sizing macros
// Depths of the source FIFOs and the log
// memory, and the widths of their counts
// ****************************************

`ifndef EVLOG_MACROS_SVH
`define EVLOG_MACROS_SVH

// Source FIFO depths
`define EVLOG_SAMPLE_DEPTH 4
`define EVLOG_FAULT_DEPTH 4

// Log memory size in entries
`define EVLOG_LOG_DEPTH 16

// Count and address widths
`define EVLOG_FIFO_CNT_BW 3
`define EVLOG_LOG_CNT_BW 5
`define EVLOG_LOG_ADDR_BW 4

`endif

/* rtl/evlog_pkg.sv */
// ****************************************
// Event logger types
// Sample, fault and log word layouts and
// the source tag carried in each log word
// ****************************************

package evlog_pkg;

	// Payload field of a log word, wide enough for a sample
	localparam int LOG_PAYLOAD_BW = 14;

	// Sensor sample: channel number and converter value
	typedef struct packed
	{
		logic [1:0] channel;
		logic [11:0] value;
	} sample_t;

	// Fault report
	typedef struct packed
	{
		logic [7:0] code;
	} fault_t;

	// Origin of a log word
	typedef enum logic
	{
		SRC_SAMPLE = 1'b0,
		SRC_FAULT = 1'b1
	} src_e;

	// One word of the log memory
	// Faults sit zero-extended in the low payload bits
	typedef struct packed
	{
		src_e src;
		logic [LOG_PAYLOAD_BW-1:0] payload;
	} log_entry_t;

endpackage

/* rtl/evlog_fifo.sv */
// ****************************************
// Payload-typed event FIFO
// Fill and free counters, circular pointers
// and show-ahead read data. In stream mode a
// write into a full FIFO drops the oldest
// ****************************************

`include "evlog_macros.svh"

module evlog_fifo
#(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4,
	parameter bit STREAM = 1'b0
)
(
	input logic clk,
	input logic rstnn,
	input logic enable,
	input logic clear,
	input logic wrequest,
	input payload_t wdata,
	output logic wfull,
	output logic [`EVLOG_FIFO_CNT_BW-1:0] wnum,
	input logic rrequest,
	output payload_t rdata,
	output logic rempty,
	output logic [`EVLOG_FIFO_CNT_BW-1:0] rnum
);

	localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Storage, no reset on payload
	payload_t mem [DEPTH];

	logic [PTR_BW-1:0] wr_ptr;
	logic [PTR_BW-1:0] rd_ptr;
	logic [`EVLOG_FIFO_CNT_BW-1:0] fill_cnt;
	logic [`EVLOG_FIFO_CNT_BW-1:0] free_cnt;
	logic wready;
	logic overwrite;
	logic push;
	logic pop;

	// Circular advance, also for depths that are not a power of two
	function automatic logic [PTR_BW-1:0] next_ptr(input logic [PTR_BW-1:0] ptr);
		if (ptr == PTR_BW'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// ****************************************
	// Flow control
	// ****************************************

	// Room for one more while not being cleared
	assign wready = !clear && (fill_cnt < DEPTH);
	assign wfull = !wready;
	assign rempty = (fill_cnt == '0);

	// Stream mode turns a write into a full FIFO into a push plus a pop
	assign overwrite = STREAM && wrequest && wfull && !clear;
	assign push = wrequest && (wready || overwrite);
	assign pop = (rrequest && !rempty) || overwrite;

	// ****************************************
	// Counters and pointers
	// ****************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			fill_cnt <= '0;
			free_cnt <= `EVLOG_FIFO_CNT_BW'(DEPTH);
		end
		else if (enable)
		begin
			if (clear)
			begin
				fill_cnt <= '0;
				free_cnt <= `EVLOG_FIFO_CNT_BW'(DEPTH);
			end
			else if (push && !pop)
			begin
				fill_cnt <= fill_cnt + 1'b1;
				free_cnt <= free_cnt - 1'b1;
			end
			else if (pop && !push)
			begin
				fill_cnt <= fill_cnt - 1'b1;
				free_cnt <= free_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (enable)
		begin
			if (clear)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end
			else
			begin
				if (push)
					wr_ptr <= next_ptr(wr_ptr);
				if (pop)
					rd_ptr <= next_ptr(rd_ptr);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (enable && push)
			mem[wr_ptr] <= wdata;
	end

	// Head of queue is visible without a read strobe
	assign rdata = mem[rd_ptr];

	assign rnum = fill_cnt;
	assign wnum = free_cnt;

	// ****************************************
	// Checks
	// ****************************************

	a_fill_bound: assert property (@(posedge clk) disable iff (!rstnn)
		fill_cnt <= DEPTH);

	a_count_sum: assert property (@(posedge clk) disable iff (!rstnn)
		fill_cnt + free_cnt == DEPTH);

	// A rejected write must leave the write pointer untouched, also during a pop
	a_no_store_full: assert property (@(posedge clk) disable iff (!rstnn)
		(!STREAM && enable && !clear && wrequest && wfull)
		|=> $stable(wr_ptr));

endmodule

/* rtl/evlog_arbiter.sv */
// ****************************************
// Round-robin log arbiter
// Picks one nonempty FIFO per cycle, pops
// it and tags its head for the log memory
// ****************************************

module evlog_arbiter
(
	input logic clk,
	input logic rstnn,
	input logic enable,
	input evlog_pkg::sample_t sample_rdata,
	input logic sample_rempty,
	output logic sample_rrequest,
	input evlog_pkg::fault_t fault_rdata,
	input logic fault_rempty,
	output logic fault_rrequest,
	input logic log_full,
	output logic store_we,
	output evlog_pkg::log_entry_t store_entry
);

	import evlog_pkg::*;

	// Source served by the most recent write
	src_e last_grant;

	logic grant_sample;
	logic grant_fault;

	// ****************************************
	// Grant selection
	// ****************************************

	always_comb
	begin
		grant_sample = 1'b0;
		grant_fault = 1'b0;
		if (!log_full)
		begin
			// Tie goes to the source not served last
			if (!sample_rempty && !fault_rempty)
			begin
				if (last_grant == SRC_SAMPLE)
					grant_fault = 1'b1;
				else
					grant_sample = 1'b1;
			end
			else if (!sample_rempty)
				grant_sample = 1'b1;
			else if (!fault_rempty)
				grant_fault = 1'b1;
		end
	end

	assign sample_rrequest = grant_sample;
	assign fault_rrequest = grant_fault;
	assign store_we = grant_sample || grant_fault;

	// Tag the granted head with its source
	always_comb
	begin
		store_entry.payload = '0;
		if (grant_fault)
		begin
			store_entry.src = SRC_FAULT;
			store_entry.payload[$bits(fault_t)-1:0] = fault_rdata;
		end
		else
		begin
			store_entry.src = SRC_SAMPLE;
			store_entry.payload = sample_rdata;
		end
	end

	// Sample counts as served at reset so fault wins the first tie
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			last_grant <= SRC_SAMPLE;
		else if (enable && store_we)
			last_grant <= grant_fault ? SRC_FAULT : SRC_SAMPLE;
	end

	// ****************************************
	// Checks
	// ****************************************

	a_one_grant: assert property (@(posedge clk) disable iff (!rstnn)
		!(sample_rrequest && fault_rrequest));

	a_req_ok: assert property (@(posedge clk) disable iff (!rstnn)
		(sample_rrequest |-> (!sample_rempty && !log_full))
		and (fault_rrequest |-> (!fault_rempty && !log_full)));

endmodule

/* rtl/evlog_store.sv */
// ****************************************
// Shared log memory
// Appends one entry per cycle until full,
// rewinds on clear, reads by address
// ****************************************

`include "evlog_macros.svh"

module evlog_store
(
	input logic clk,
	input logic rstnn,
	input logic enable,
	input logic log_clear,
	input logic store_we,
	input evlog_pkg::log_entry_t store_entry,
	output logic log_full,
	output logic [`EVLOG_LOG_CNT_BW-1:0] log_count,
	input logic [`EVLOG_LOG_ADDR_BW-1:0] log_addr,
	output evlog_pkg::log_entry_t log_entry
);

	import evlog_pkg::*;

	// Log words keep their contents across a clear
	log_entry_t mem [`EVLOG_LOG_DEPTH];

	logic [`EVLOG_LOG_ADDR_BW-1:0] wr_ptr;
	logic wr_en;

	// Clear has priority over a write in the same cycle
	assign wr_en = enable && store_we && !log_full && !log_clear;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			wr_ptr <= '0;
			log_full <= 1'b0;
		end
		else if (enable && log_clear)
		begin
			wr_ptr <= '0;
			log_full <= 1'b0;
		end
		else if (wr_en)
		begin
			wr_ptr <= wr_ptr + 1'b1;
			// Last slot taken
			if (wr_ptr == `EVLOG_LOG_ADDR_BW'(`EVLOG_LOG_DEPTH - 1))
				log_full <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= store_entry;
	end

	// Pointer wraps to zero when full, so the flag supplies the top count
	assign log_count = log_full ? `EVLOG_LOG_CNT_BW'(`EVLOG_LOG_DEPTH)
		: `EVLOG_LOG_CNT_BW'(wr_ptr);

	// Readout, no latency
	assign log_entry = mem[log_addr];

	// Arbiter must hold off once the log is full
	a_no_write_full: assert property (@(posedge clk) disable iff (!rstnn)
		log_full |-> !store_we);

endmodule

/* rtl/evlog_top.sv */
// ****************************************
// Event logger top level
// Sample and fault FIFOs drained by a
// round-robin arbiter into the log memory
// ****************************************

`include "evlog_macros.svh"

module evlog_top
(
	input logic clk,
	input logic rstnn,
	input logic enable,
	input logic sample_valid,
	input evlog_pkg::sample_t sample_in,
	output logic [`EVLOG_FIFO_CNT_BW-1:0] sample_count,
	input logic fault_valid,
	input evlog_pkg::fault_t fault_in,
	output logic fault_full,
	output logic [`EVLOG_FIFO_CNT_BW-1:0] fault_count,
	input logic log_clear,
	input logic [`EVLOG_LOG_ADDR_BW-1:0] log_addr,
	output evlog_pkg::log_entry_t log_entry,
	output logic [`EVLOG_LOG_CNT_BW-1:0] log_count,
	output logic log_full
);

	import evlog_pkg::*;

	sample_t sample_rdata;
	logic sample_rempty;
	logic sample_rrequest;
	fault_t fault_rdata;
	logic fault_rempty;
	logic fault_rrequest;
	logic store_we;
	log_entry_t store_entry;

	// Samples overwrite the oldest when full
	evlog_fifo
	#(
		.payload_t(sample_t),
		.DEPTH(`EVLOG_SAMPLE_DEPTH),
		.STREAM(1'b1)
	)
	sample_fifo_inst
	(
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(1'b0),
		.wrequest(sample_valid),
		.wdata(sample_in),
		.wfull(),
		.wnum(),
		.rrequest(sample_rrequest),
		.rdata(sample_rdata),
		.rempty(sample_rempty),
		.rnum(sample_count)
	);

	// Faults are rejected when full
	evlog_fifo
	#(
		.payload_t(fault_t),
		.DEPTH(`EVLOG_FAULT_DEPTH),
		.STREAM(1'b0)
	)
	fault_fifo_inst
	(
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(1'b0),
		.wrequest(fault_valid),
		.wdata(fault_in),
		.wfull(fault_full),
		.wnum(),
		.rrequest(fault_rrequest),
		.rdata(fault_rdata),
		.rempty(fault_rempty),
		.rnum(fault_count)
	);

	evlog_arbiter arbiter_inst
	(
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.sample_rdata(sample_rdata),
		.sample_rempty(sample_rempty),
		.sample_rrequest(sample_rrequest),
		.fault_rdata(fault_rdata),
		.fault_rempty(fault_rempty),
		.fault_rrequest(fault_rrequest),
		.log_full(log_full),
		.store_we(store_we),
		.store_entry(store_entry)
	);

	evlog_store store_inst
	(
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.log_clear(log_clear),
		.store_we(store_we),
		.store_entry(store_entry),
		.log_full(log_full),
		.log_count(log_count),
		.log_addr(log_addr),
		.log_entry(log_entry)
	);

endmodule

/* bench/evlog_tb.sv */
// ****************************************
// Event logger testbench
// Table-driven pushes, clears and log
// readouts, checked every cycle against a
// queue model of both sources and the log
// ****************************************

`include "evlog_macros.svh"

module evlog_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import evlog_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS = 27;

	// ****************************************
	// Stimulus table
	// ****************************************

	typedef enum
	{
		OP_SAMPLE,
		OP_FAULT,
		OP_BOTH,
		OP_IDLE,
		OP_CLEAR,
		OP_CHECK
	} op_e;

	// Push and idle rows repeat arg cycles, check rows carry the expected log count
	typedef struct
	{
		op_e op;
		int arg;
		int exp_count;
	} row_t;

	row_t stim_rows [NUM_ROWS] = '{
		'{OP_CHECK, 0, 0},
		// Mixed traffic with room in the log
		'{OP_SAMPLE, 1, 0},
		'{OP_FAULT, 1, 0},
		'{OP_BOTH, 1, 0},
		'{OP_SAMPLE, 1, 0},
		'{OP_BOTH, 1, 0},
		'{OP_FAULT, 1, 0},
		'{OP_IDLE, 4, 0},
		'{OP_CHECK, 0, 8},
		// Fill the log to the top
		'{OP_BOTH, 4, 0},
		'{OP_IDLE, 6, 0},
		'{OP_CHECK, 0, 16},
		// Six samples against a blocked log
		'{OP_SAMPLE, 6, 0},
		'{OP_CHECK, 0, 16},
		'{OP_CLEAR, 1, 0},
		'{OP_IDLE, 6, 0},
		'{OP_CHECK, 0, 4},
		// Refill, then overflow the fault FIFO
		'{OP_BOTH, 6, 0},
		'{OP_IDLE, 8, 0},
		'{OP_CHECK, 0, 16},
		'{OP_FAULT, 6, 0},
		'{OP_CHECK, 0, 16},
		'{OP_SAMPLE, 4, 0},
		'{OP_CHECK, 0, 16},
		// Both FIFOs full, drain after clear
		'{OP_CLEAR, 1, 0},
		'{OP_IDLE, 10, 0},
		'{OP_CHECK, 0, 8}
	};

	logic clk;
	logic rstnn;
	logic enable;
	logic sample_valid;
	sample_t sample_in;
	logic [`EVLOG_FIFO_CNT_BW-1:0] sample_count;
	logic fault_valid;
	fault_t fault_in;
	logic fault_full;
	logic [`EVLOG_FIFO_CNT_BW-1:0] fault_count;
	logic log_clear;
	logic [`EVLOG_LOG_ADDR_BW-1:0] log_addr;
	log_entry_t log_entry;
	logic [`EVLOG_LOG_CNT_BW-1:0] log_count;
	logic log_full;

	// Reference model state
	sample_t sq [$];
	fault_t fq [$];
	log_entry_t m_log [`EVLOG_LOG_DEPTH];
	int m_cnt;
	bit m_last_fault;

	logic [31:0] rng_state = 32'hf3a4b5aa;
	log_entry_t rd_entry;
	int errors;

	evlog_top evlog_top_inst
	(
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.sample_valid(sample_valid),
		.sample_in(sample_in),
		.sample_count(sample_count),
		.fault_valid(fault_valid),
		.fault_in(fault_in),
		.fault_full(fault_full),
		.fault_count(fault_count),
		.log_clear(log_clear),
		.log_addr(log_addr),
		.log_entry(log_entry),
		.log_count(log_count),
		.log_full(log_full)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// ****************************************
	// Helpers
	// ****************************************

	// Xorshift32 payload source
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("Test FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// One rising edge of the logger as seen from the source side
	task automatic model_step(input bit ps, input sample_t sv, input bit pf,
		input fault_t fv, input bit clr);
		int s_n;
		int f_n;
		bit gs;
		bit gf;
		fault_t f;
		log_entry_t e;
		s_n = sq.size();
		f_n = fq.size();
		gs = 1'b0;
		gf = 1'b0;
		// Round robin, tie goes to the source not served last
		if (m_cnt < `EVLOG_LOG_DEPTH)
		begin
			if (s_n > 0 && f_n > 0)
			begin
				gs = m_last_fault;
				gf = !m_last_fault;
			end
			else if (s_n > 0)
				gs = 1'b1;
			else if (f_n > 0)
				gf = 1'b1;
		end
		if (gs)
		begin
			e.src = SRC_SAMPLE;
			e.payload = sq.pop_front();
			m_last_fault = 1'b0;
		end
		if (gf)
		begin
			f = fq.pop_front();
			e.src = SRC_FAULT;
			e.payload = {6'b000000, f};
			m_last_fault = 1'b1;
		end
		// Popped head is lost when a clear hits the same edge
		if (clr)
			m_cnt = 0;
		else if (gs || gf)
		begin
			m_log[m_cnt] = e;
			m_cnt++;
		end
		// Full sample FIFO drops its head unless the log took it
		if (ps)
		begin
			if (s_n == `EVLOG_SAMPLE_DEPTH && !gs)
				void'(sq.pop_front());
			sq.push_back(sv);
		end
		// Full fault FIFO rejects, even with a pop on the same edge
		if (pf && f_n < `EVLOG_FAULT_DEPTH)
			fq.push_back(fv);
	endtask

	task automatic check_status();
		check_value(sample_count, sq.size(), "sample_count");
		check_value(fault_count, fq.size(), "fault_count");
		check_value(fault_full, fq.size() == `EVLOG_FAULT_DEPTH, "fault_full");
		check_value(log_count, m_cnt, "log_count");
		check_value(log_full, m_cnt == `EVLOG_LOG_DEPTH, "log_full");
	endtask

	// Starts and ends on a falling edge, log word captured mid low phase
	task automatic run_cycle(input bit ps, input bit pf, input bit clr, input int addr);
		logic [31:0] r;
		sample_t sv;
		fault_t fv;
		r = next_rand();
		sv = r[13:0];
		r = next_rand();
		fv = r[7:0];
		sample_valid = ps;
		sample_in = sv;
		fault_valid = pf;
		fault_in = fv;
		log_clear = clr;
		log_addr = addr[`EVLOG_LOG_ADDR_BW-1:0];
		#(CLK_PERIOD / 4);
		rd_entry = log_entry;
		model_step(ps, sv, pf, fv, clr);
		@(negedge clk);
		check_status();
	endtask

	// Count against table, then every stored word
	task automatic check_log(input int exp_count);
		int n;
		check_value(log_count, exp_count, "log_count against table");
		n = m_cnt;
		for (int i = 0; i < n; i++)
		begin
			run_cycle(1'b0, 1'b0, 1'b0, i);
			check_value(rd_entry, m_log[i], $sformatf("log word %0d", i));
		end
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial
	begin
		errors = 0;
		m_cnt = 0;
		m_last_fault = 1'b0;
		rstnn = 1'b0;
		enable = 1'b1;
		sample_valid = 1'b0;
		sample_in = '0;
		fault_valid = 1'b0;
		fault_in = '0;
		log_clear = 1'b0;
		log_addr = '0;
		repeat (16)
			@(negedge clk);
		rstnn = 1'b1;
		check_status();
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			case (stim_rows[r].op)
				OP_SAMPLE:
					repeat (stim_rows[r].arg)
						run_cycle(1'b1, 1'b0, 1'b0, 0);
				OP_FAULT:
					repeat (stim_rows[r].arg)
						run_cycle(1'b0, 1'b1, 1'b0, 0);
				OP_BOTH:
					repeat (stim_rows[r].arg)
						run_cycle(1'b1, 1'b1, 1'b0, 0);
				OP_IDLE:
					repeat (stim_rows[r].arg)
						run_cycle(1'b0, 1'b0, 1'b0, 0);
				OP_CLEAR:
					repeat (stim_rows[r].arg)
						run_cycle(1'b0, 1'b0, 1'b1, 0);
				default:
					check_log(stim_rows[r].exp_count);
			endcase
		end
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Budget of 64 cycles per table row plus reset
	initial
	begin
		#((NUM_ROWS * 64 + 16) * CLK_PERIOD);
		$display("Watchdog expired before the stimulus table was finished");
		$display("Test FAILED");
		$fatal(1, "Run stopped by watchdog");
	end

endmodule

/* filelist.f */
+incdir+rtl
rtl/evlog_pkg.sv
rtl/evlog_fifo.sv
rtl/evlog_arbiter.sv
rtl/evlog_store.sv
rtl/evlog_top.sv
bench/evlog_tb.sv

/* Bender.yml */
package:
  name: evlog

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/evlog_pkg.sv
      - rtl/evlog_fifo.sv
      - rtl/evlog_arbiter.sv
      - rtl/evlog_store.sv
      - rtl/evlog_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - bench/evlog_tb.sv
